/* sim.f */
logic/gb_bus_pkg.sv
logic/spram.sv
logic/oam_dma.sv
logic/mem_arbiter.sv
logic/wb_cpu_port.sv
logic/gb_bus_top.sv
tests/gb_bus_assert.sv
tests/tb_gb_bus.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_gb_bus
FILELIST  ?= sim.f
LOG       ?= sim.log
BIN       := obj_dir/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	./$(BIN) +verilator+error+limit+100 2>&1 | tee $(LOG)
	@grep -q "all tests passed" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* tests/tb_gb_bus.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_gb_bus;

	import gb_bus_pkg::*;

	localparam int PERIOD   = 20;
	localparam int N_RAND   = 24;
	localparam int N_OAM    = 16;
	localparam int N_OTHER  = 17; // Register, lockout and unmapped accesses.
	localparam int ACCESSES = 2*N_RAND + 2*N_OAM + 3*OAM_LEN + N_OTHER;
	localparam int DMAS     = 2;
	localparam int WATCHDOG_CYCLES = 20*ACCESSES + 200*DMAS + 5;

	logic        gbclk = 1'b0;
	logic        rst;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [15:0] adr;
	logic  [7:0] dat_w;
	wire   [7:0] dat_r;
	wire         ack;
	wire         dma_active;

	logic  [7:0] model [int]; // Expected RAM bytes by bus address.
	logic [15:0] addrs [$];
	logic [15:0] lock_addr = 16'hd123;

	gb_bus_top gb_bus_top_i (
		.gbclk      (gbclk),
		.rst        (rst),
		.cyc        (cyc),
		.stb        (stb),
		.we         (we),
		.adr        (adr),
		.dat_w      (dat_w),
		.dat_r      (dat_r),
		.ack        (ack),
		.dma_active (dma_active)
	);

	always #(PERIOD/2) gbclk = ~gbclk;

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("tests failed");
		$fatal(1);
	endtask

	// One Wishbone classic cycle, driven on falling edges.
	task automatic bus_access(input logic wr, input logic [15:0] addr,
			input logic [7:0] data, output logic [7:0] rdata);
		@(negedge gbclk);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = wr;
		adr   = addr;
		dat_w = data;
		do
			@(negedge gbclk);
		while (!ack);
		rdata = dat_r;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
	endtask

	task automatic write_byte(input logic [15:0] addr, input logic [7:0] data);
		logic [7:0] rdata;
		bus_access(1'b1, addr, data, rdata);
		model[int'(addr)] = data;
	endtask

	task automatic read_expect(input logic [15:0] addr, input logic [7:0] exp);
		logic [7:0] got;
		bus_access(1'b0, addr, 8'h00, got);
		assert (got === exp)
		else abort_run($sformatf("mismatch dat_r at %h: expected %h, got %h", addr, exp, got));
	endtask

	task automatic check_model(input logic [15:0] addr);
		read_expect(addr, model[int'(addr)]);
	endtask

	task automatic start_dma(input logic [7:0] page);
		logic [7:0] rdata;
		bus_access(1'b1, 16'hff46, page, rdata);
		assert (dma_active === 1'b1)
		else abort_run($sformatf("mismatch dma_active: expected %h, got %h", 1'b1, dma_active));
	endtask

	task automatic wait_dma();
		while (dma_active)
			@(negedge gbclk);
	endtask

	always @(negedge gbclk)
		if (gb_bus_top_i.gb_bus_assert_i.fail_count != 0)
			abort_run("a bound protocol assertion failed");

	initial begin
		#(WATCHDOG_CYCLES * PERIOD);
		abort_run("timeout, the bus or the DMA stopped responding");
	end

	initial begin
		logic [15:0] a;
		logic  [7:0] d;
		void'($urandom(32'hb31));
		rst   = 1'b1;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = 16'h0000;
		dat_w = 8'h00;
		repeat (5) @(negedge gbclk);
		rst = 1'b0;

		repeat (N_RAND) begin
			a = WRAM_BASE + 16'($urandom_range(8191));
			write_byte(a, 8'($urandom));
			addrs.push_back(a);
		end
		foreach (addrs[k])
			check_model(addrs[k]);

		for (int i = 0; i < N_OAM; i++)
			write_byte(OAM_BASE + 16'(i * 10), 8'($urandom));
		for (int i = 0; i < N_OAM; i++)
			check_model(OAM_BASE + 16'(i * 10));

		// Source page in WRAM locks both RAMs.
		write_byte(lock_addr, 8'h3c);
		for (int i = 0; i < OAM_LEN; i++)
			write_byte({8'hc1, 8'(i)}, 8'($urandom));
		start_dma(8'hc1);
		read_expect(OAM_BASE + 16'd5, OPEN_BUS);
		read_expect(lock_addr, OPEN_BUS);
		bus_access(1'b1, lock_addr, 8'h5a, d);
		bus_access(1'b1, OAM_BASE, 8'h5a, d);
		wait_dma();
		for (int i = 0; i < OAM_LEN; i++) begin
			model[int'(OAM_BASE) + i] = model[int'({8'hc1, 8'(i)})];
			check_model(OAM_BASE + 16'(i));
		end
		read_expect(16'hff46, 8'hc1);
		check_model(lock_addr);

		// Last OAM byte is copied only at the end of the transfer.
		write_byte(OAM_BASE + 16'd159, 8'h42);
		start_dma(8'h80);
		check_model(lock_addr); // WRAM stays open.
		read_expect(OAM_BASE + 16'd159, OPEN_BUS);
		wait_dma();
		for (int i = 0; i < OAM_LEN; i++)
			read_expect(OAM_BASE + 16'(i), OPEN_BUS);
		read_expect(16'hff46, 8'h80);

		read_expect(16'h0123, OPEN_BUS);
		read_expect(16'he000, OPEN_BUS);
		read_expect(16'hfea0, OPEN_BUS);
		read_expect(16'hff00, OPEN_BUS);

		$display("all tests passed");
		$finish;
	end

endmodule

`default_nettype wire

/* tests/gb_bus_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module gb_bus_assert (
	input wire gbclk,
	input wire rst,
	input wire cyc,
	input wire stb,
	input wire ack,
	input wire dma_active
);

	int fail_count = 0;
	int run_len;

	// Cycles the current transfer has been active.
	always_ff @(posedge gbclk) begin
		if (rst || !dma_active)
			run_len <= 0;
		else
			run_len <= run_len + 1;
	end

	assert property (@(posedge gbclk) disable iff (rst) (cyc && stb && !ack) |=> ack)
	else begin
		fail_count++;
		$error("ack did not follow the strobe by one cycle");
	end

	assert property (@(posedge gbclk) disable iff (rst) ack |=> !ack)
	else begin
		fail_count++;
		$error("ack stayed high for two cycles");
	end

	assert property (@(posedge gbclk) disable iff (rst) $rose(ack) |-> $past(cyc && stb))
	else begin
		fail_count++;
		$error("ack rose without a bus cycle");
	end

	// Length of a transfer that is not restarted.
	assert property (@(posedge gbclk) disable iff (rst) $fell(dma_active) |-> run_len == 161)
	else begin
		fail_count++;
		$error("dma_active did not last 161 cycles");
	end

endmodule

bind gb_bus_top gb_bus_assert gb_bus_assert_i (
	.gbclk      (gbclk),
	.rst        (rst),
	.cyc        (cyc),
	.stb        (stb),
	.ack        (ack),
	.dma_active (dma_active)
);

`default_nettype wire

/* logic/gb_bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module gb_bus_top #(
	parameter int WRAM_DEPTH = 2**gb_bus_pkg::WRAM_AW,
	parameter int OAM_DEPTH  = gb_bus_pkg::OAM_LEN
) (
	input  wire                           gbclk,
	input  wire                           rst,
	input  wire                           cyc,
	input  wire                           stb,
	input  wire                           we,
	input  wire [gb_bus_pkg::ADDR_W-1:0]  adr,
	input  wire [gb_bus_pkg::DATA_W-1:0]  dat_w,
	output logic [gb_bus_pkg::DATA_W-1:0] dat_r,
	output logic                          ack,
	output logic                          dma_active
);

	import gb_bus_pkg::*;

	mem_req_t          cpu_req;
	mem_req_t          dma_rd;
	mem_req_t          dma_wr;
	logic [DATA_W-1:0] cpu_rdata;
	logic              cpu_blocked;
	logic [DATA_W-1:0] dma_rdata;
	logic              dma_start;
	logic        [7:0] dma_page;
	logic        [7:0] dma_reg;

	wb_cpu_port wb_cpu_port_i (
		.gbclk       (gbclk),
		.rst         (rst),
		.cyc         (cyc),
		.stb         (stb),
		.we          (we),
		.adr         (adr),
		.dat_w       (dat_w),
		.dat_r       (dat_r),
		.ack         (ack),
		.cpu_req     (cpu_req),
		.cpu_rdata   (cpu_rdata),
		.cpu_blocked (cpu_blocked),
		.dma_start   (dma_start),
		.dma_page    (dma_page),
		.dma_reg     (dma_reg)
	);

	oam_dma oam_dma_i (
		.gbclk      (gbclk),
		.rst        (rst),
		.dma_start  (dma_start),
		.dma_page   (dma_page),
		.dma_rdata  (dma_rdata),
		.dma_rd     (dma_rd),
		.dma_wr     (dma_wr),
		.dma_active (dma_active),
		.dma_reg    (dma_reg)
	);

	// Lockout follows the page of the running transfer.
	mem_arbiter #(
		.WRAM_DEPTH (WRAM_DEPTH),
		.OAM_DEPTH  (OAM_DEPTH)
	) mem_arbiter_i (
		.gbclk       (gbclk),
		.cpu_req     (cpu_req),
		.dma_rd      (dma_rd),
		.dma_wr      (dma_wr),
		.dma_active  (dma_active),
		.dma_page    (dma_reg),
		.cpu_rdata   (cpu_rdata),
		.cpu_blocked (cpu_blocked),
		.dma_rdata   (dma_rdata)
	);

endmodule

`default_nettype wire

/* logic/wb_cpu_port.sv */
`timescale 1ns/1ps
`default_nettype none

module wb_cpu_port (
	input  wire                           gbclk,
	input  wire                           rst,
	input  wire                           cyc,
	input  wire                           stb,
	input  wire                           we,
	input  wire gb_bus_pkg::cpu_addr_u    adr,
	input  wire [gb_bus_pkg::DATA_W-1:0]  dat_w,
	output logic [gb_bus_pkg::DATA_W-1:0] dat_r,
	output logic                          ack,
	output gb_bus_pkg::mem_req_t          cpu_req,
	input  wire [gb_bus_pkg::DATA_W-1:0]  cpu_rdata,
	input  wire                           cpu_blocked,
	output logic                          dma_start,
	output logic                    [7:0] dma_page,
	input  wire                     [7:0] dma_reg
);

	import gb_bus_pkg::*;

	logic    new_access; // Strobe not yet acknowledged.
	region_e region;
	region_e region_q;
	logic    is_mem;

	assign new_access = cyc && stb && !ack;
	assign region     = decode_region(adr);
	assign is_mem     = region == region_wram || region == region_oam;

	always_comb begin
		cpu_req       = '0;
		cpu_req.en    = new_access && is_mem;
		cpu_req.we    = we;
		cpu_req.addr  = adr;
		cpu_req.wdata = dat_w;
	end

	assign dma_start = new_access && we && region == region_dma_reg;
	assign dma_page  = dat_w;

	always_ff @(posedge gbclk) begin
		if (rst) begin
			ack      <= 1'b0;
			region_q <= region_none;
		end else begin
			ack <= new_access;
			if (new_access)
				region_q <= region;
		end
	end

	// Read result lines up with ack.
	always_comb begin
		case (region_q)
		region_wram, region_oam:
			dat_r = cpu_blocked ? OPEN_BUS : cpu_rdata;
		region_dma_reg:
			dat_r = dma_reg;
		default:
			dat_r = OPEN_BUS; // Unmapped.
		endcase
	end

endmodule

`default_nettype wire

/* logic/mem_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter #(
	parameter int WRAM_DEPTH = 8192,
	parameter int OAM_DEPTH  = 160
) (
	input  wire                                gbclk,
	input  wire gb_bus_pkg::mem_req_t          cpu_req,
	input  wire gb_bus_pkg::mem_req_t          dma_rd,
	input  wire gb_bus_pkg::mem_req_t          dma_wr,
	input  wire                                dma_active,
	input  wire                          [7:0] dma_page,
	output logic [gb_bus_pkg::DATA_W-1:0]      cpu_rdata,
	output logic                               cpu_blocked,
	output logic [gb_bus_pkg::DATA_W-1:0]      dma_rdata
);

	import gb_bus_pkg::*;

	localparam int WAW = $clog2(WRAM_DEPTH);
	localparam int OAW = $clog2(OAM_DEPTH);

	region_e     cpu_region;
	cpu_addr_u   src_base;
	logic        src_in_wram;
	logic        blocked;
	logic        wram_en, wram_we, oam_en, oam_we;
	logic [WAW-1:0] wram_addr;
	logic [OAW-1:0] oam_addr;
	logic [7:0]  wram_wdata, oam_wdata;
	logic [7:0]  wram_rdata, oam_rdata;
	logic        sel_oam_q;
	logic        src_wram_q;

	assign src_base.io.page  = dma_page;
	assign src_base.io.index = 8'h00;
	assign src_in_wram = decode_region(src_base) == region_wram;
	assign cpu_region  = decode_region(cpu_req.addr);
	assign blocked = dma_active && (cpu_region == region_oam ||
		(cpu_region == region_wram && src_in_wram));

	always_comb begin
		if (dma_rd.en && src_in_wram) begin // DMA first.
			wram_en    = 1'b1;
			wram_we    = 1'b0;
			wram_addr  = dma_rd.addr.full[WAW-1:0];
			wram_wdata = dma_rd.wdata;
		end else begin
			wram_en    = cpu_req.en && cpu_region == region_wram && !blocked;
			wram_we    = cpu_req.we;
			wram_addr  = cpu_req.addr.full[WAW-1:0];
			wram_wdata = cpu_req.wdata;
		end
		if (dma_wr.en) begin
			oam_en    = 1'b1;
			oam_we    = dma_wr.we;
			oam_addr  = dma_wr.addr.full[OAW-1:0];
			oam_wdata = dma_wr.wdata;
		end else begin
			oam_en    = cpu_req.en && cpu_region == region_oam && !blocked;
			oam_we    = cpu_req.we;
			oam_addr  = cpu_req.addr.full[OAW-1:0];
			oam_wdata = cpu_req.wdata;
		end
	end

	always_ff @(posedge gbclk) begin
		sel_oam_q   <= cpu_region == region_oam;
		cpu_blocked <= cpu_req.en && blocked;
		src_wram_q  <= decode_region(dma_rd.addr) == region_wram;
	end

	assign cpu_rdata = sel_oam_q ? oam_rdata : wram_rdata;
	assign dma_rdata = src_wram_q ? wram_rdata : OPEN_BUS; // No other source memory.

	spram #(.AW(WAW), .DEPTH(WRAM_DEPTH)) wram (
		.gbclk (gbclk),
		.en    (wram_en),
		.we    (wram_we),
		.addr  (wram_addr),
		.wdata (wram_wdata),
		.rdata (wram_rdata)
	);

	spram #(.AW(OAW), .DEPTH(OAM_DEPTH)) oam (
		.gbclk (gbclk),
		.en    (oam_en),
		.we    (oam_we),
		.addr  (oam_addr),
		.wdata (oam_wdata),
		.rdata (oam_rdata)
	);

endmodule

`default_nettype wire

/* logic/oam_dma.sv */
`timescale 1ns/1ps
`default_nettype none

module oam_dma (
	input  wire                  gbclk,
	input  wire                  rst,
	input  wire                  dma_start,
	input  wire            [7:0] dma_page,
	input  wire            [7:0] dma_rdata,
	output gb_bus_pkg::mem_req_t dma_rd,
	output gb_bus_pkg::mem_req_t dma_wr,
	output logic                 dma_active,
	output logic           [7:0] dma_reg
);

	import gb_bus_pkg::*;

	logic       reading;  // Source reads still to issue.
	logic [7:0] cnt;
	logic       wr_valid; // A source byte arrives this cycle.
	logic [7:0] wr_idx;

	always_ff @(posedge gbclk) begin
		if (rst) begin
			dma_reg  <= 8'h00;
			reading  <= 1'b0;
			cnt      <= 8'h00;
			wr_valid <= 1'b0;
		end else if (dma_start) begin
			dma_reg  <= dma_page;
			reading  <= 1'b1;
			cnt      <= 8'h00;
			wr_valid <= 1'b0; // Byte of the old page is dropped.
		end else begin
			wr_valid <= reading;
			if (reading) begin
				cnt <= cnt + 8'd1;
				if (cnt == 8'(OAM_LEN - 1))
					reading <= 1'b0;
			end
		end
	end

	// OAM index trails the read counter by one cycle.
	always_ff @(posedge gbclk)
		wr_idx <= cnt;

	always_comb begin
		dma_rd             = '0;
		dma_rd.en          = reading;
		dma_rd.addr.io.page  = dma_reg;
		dma_rd.addr.io.index = cnt;

		dma_wr           = '0;
		dma_wr.en        = wr_valid;
		dma_wr.we        = wr_valid;
		dma_wr.addr.full = OAM_BASE + {8'h00, wr_idx};
		dma_wr.wdata     = dma_rdata;
	end

	assign dma_active = reading | wr_valid;

endmodule

`default_nettype wire

/* logic/spram.sv */
`timescale 1ns/1ps
`default_nettype none

module spram #(
	parameter int AW    = 8,
	parameter int DEPTH = 256
) (
	input  wire          gbclk,
	input  wire          en,
	input  wire          we,
	input  wire [AW-1:0] addr,
	input  wire    [7:0] wdata,
	output logic   [7:0] rdata
);

	logic [7:0] mem [DEPTH];

	always_ff @(posedge gbclk) begin
		if (en) begin
			if (we)
				mem[addr] <= wdata;
			rdata <= mem[addr]; // Old contents on a write.
		end
	end

endmodule

`default_nettype wire

/* logic/gb_bus_pkg.sv */
`default_nettype none

package gb_bus_pkg;

	localparam int ADDR_W = 16;
	localparam int DATA_W = 8;

	localparam logic [ADDR_W-1:0] WRAM_BASE = 16'hc000;
	localparam int                WRAM_AW   = 13; // 8 KiB.

	localparam logic [ADDR_W-1:0] OAM_BASE = 16'hfe00;
	localparam int                OAM_LEN  = 160;

	localparam logic [7:0] IO_PAGE       = 8'hff;
	localparam logic [7:0] DMA_REG_INDEX = 8'h46;

	localparam logic [DATA_W-1:0] OPEN_BUS = 8'hff;

	localparam logic [ADDR_W-1:0] WRAM_LAST = ADDR_W'(WRAM_BASE + 2**WRAM_AW - 1);
	localparam logic [ADDR_W-1:0] OAM_LAST  = ADDR_W'(OAM_BASE + OAM_LEN - 1);

	typedef enum logic [1:0] {
		region_none,
		region_wram,
		region_oam,
		region_dma_reg
	} region_e;

	typedef union packed {
		logic [ADDR_W-1:0] full;
		struct packed {
			logic [7:0] page;
			logic [7:0] index; // Register offset on the I/O page.
		} io;
	} cpu_addr_u;

	typedef struct packed {
		logic              en;
		logic              we;
		cpu_addr_u         addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

	function automatic region_e decode_region(cpu_addr_u a);
		region_e r;
		r = region_none;
		if (a.full >= WRAM_BASE && a.full <= WRAM_LAST)
			r = region_wram;
		else if (a.full >= OAM_BASE && a.full <= OAM_LAST)
			r = region_oam;
		else if (a.io.page == IO_PAGE && a.io.index == DMA_REG_INDEX)
			r = region_dma_reg;
		return r;
	endfunction

endpackage

`default_nettype wire
